//--- verilog/huff_pkg.sv
package huff_pkg;

	// symbol format
	parameter int SYMBOL_W = 4;

	// a code is left aligned with the first bit on the wire in its top bit
	parameter int CODE_W = 9;
	parameter int LEN_W = 4;

	// one table entry is {code, length}
	parameter int ENTRY_W = CODE_W + LEN_W;
	parameter int N_ENTRIES = 10;
	parameter int TABLE_W = N_ENTRIES * ENTRY_W;

	// 256 symbols of 9 bits each still fit without wrap
	parameter int COUNT_W = 16;

	typedef logic [SYMBOL_W-1:0] symbol_t;

	typedef logic [CODE_W-1:0] code_bits_t;

	// only 1 to 9 are real lengths
	typedef logic [LEN_W-1:0] code_len_t;

	// entry k sits at bits 13k upward and is picked by symbol k+1
	typedef logic [TABLE_W-1:0] code_table_t;

	typedef logic [COUNT_W-1:0] bit_count_t;

endpackage

//--- verilog/symbol_reader.sv
module symbol_reader #(
	parameter int N_SYMBOLS = 256
) (
	input  logic                                    CLK,
	input  logic                                    nRST,
	input  logic                                    run,
	input  logic [N_SYMBOLS*huff_pkg::SYMBOL_W-1:0] character_in,
	output huff_pkg::symbol_t                       sym,
	output logic                                    sym_valid,
	output logic                                    sym_last
);
	import huff_pkg::*;

	localparam int WORD_W = N_SYMBOLS * SYMBOL_W;
	localparam int IDX_W = (N_SYMBOLS > 1) ? $clog2(N_SYMBOLS) : 1;

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_finished
	} state_t;

	state_t state;
	logic [IDX_W-1:0] idx;
	logic [WORD_W-1:0] word_q;
	logic at_last;
	logic load_word;
	logic take_sym;

	assign at_last = (idx == IDX_W'(N_SYMBOLS - 1));

	// everything only moves on an enabled edge
	assign load_word = run && (state == st_idle);
	assign take_sym = run && (state == st_issue);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= st_idle;
			idx <= '0;
			sym_valid <= 1'b0;
			sym_last <= 1'b0;
		end else begin
			// strobes are single cycle
			sym_valid <= 1'b0;
			sym_last <= 1'b0;
			case (state)
				st_idle: begin
					if (load_word) begin
						idx <= '0;
						state <= st_issue;
					end
				end
				st_issue: begin
					if (take_sym) begin
						sym_valid <= 1'b1;
						sym_last <= at_last;
						idx <= idx + 1'b1;
						if (at_last) begin
							state <= st_finished;
						end
					end
				end
				st_finished: begin
					// stays here until the next reset
					state <= st_finished;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// lowest nibble leaves first
	always_ff @(posedge CLK) begin
		if (load_word) begin
			word_q <= character_in;
		end else if (take_sym) begin
			sym <= word_q[SYMBOL_W-1:0];
			word_q <= word_q >> SYMBOL_W;
		end
	end

endmodule

//--- verilog/code_lookup.sv
module code_lookup (
	input  logic                  CLK,
	input  logic                  nRST,
	input  huff_pkg::code_table_t code_table,
	input  huff_pkg::symbol_t     sym,
	input  logic                  sym_valid,
	input  logic                  sym_last,
	output huff_pkg::code_bits_t  code,
	output huff_pkg::code_len_t   code_len,
	output logic                  code_valid,
	output logic                  code_last
);
	import huff_pkg::*;

	logic [ENTRY_W-1:0] entries [N_ENTRIES];
	logic sym_hit;
	symbol_t entry_idx;
	logic [ENTRY_W-1:0] entry;
	code_bits_t sel_code;
	code_len_t sel_len;
	logic len_ok;
	logic hit;

	// split the flat table into its entries
	always_comb begin
		for (int k = 0; k < N_ENTRIES; k++) begin
			entries[k] = code_table[k*ENTRY_W +: ENTRY_W];
		end
	end

	// symbols 1 to 10 map to entries 0 to 9
	assign sym_hit = (sym != '0) && (sym <= symbol_t'(N_ENTRIES));
	assign entry_idx = sym_hit ? (sym - symbol_t'(1)) : '0;
	assign entry = entries[entry_idx];

	assign sel_code = entry[ENTRY_W-1:LEN_W];
	assign sel_len = entry[LEN_W-1:0];

	// zero or oversize lengths emit nothing
	assign len_ok = (sel_len != '0) && (sel_len <= code_len_t'(CODE_W));
	assign hit = sym_valid && sym_hit && len_ok;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			code_valid <= 1'b0;
			code_last <= 1'b0;
		end else begin
			code_valid <= hit;
			// the last marker passes even when the code was dropped
			code_last <= sym_valid && sym_last;
		end
	end

	always_ff @(posedge CLK) begin
		if (hit) begin
			code <= sel_code;
			code_len <= sel_len;
		end
	end

endmodule

//--- verilog/bit_packer.sv
module bit_packer #(
	parameter int OUT_BITS = 1024
) (
	input  logic                 CLK,
	input  logic                 nRST,
	input  huff_pkg::code_bits_t code,
	input  huff_pkg::code_len_t  code_len,
	input  logic                 code_valid,
	input  logic                 code_last,
	output logic [OUT_BITS-1:0]  packed_bits,
	output huff_pkg::bit_count_t bit_count,
	output logic                 done
);
	import huff_pkg::*;

	localparam int POS_W = (OUT_BITS > 1) ? $clog2(OUT_BITS) : 1;

	logic [OUT_BITS-1:0] next_bits;
	bit_count_t next_count;

	// place the top code_len bits of the code from bit_count upward
	always_comb begin
		bit_count_t pos;
		next_bits = packed_bits;
		for (int i = 0; i < CODE_W; i++) begin
			pos = bit_count + bit_count_t'(i);
			// bits past the end of the vector are counted but dropped
			if ((i < int'(code_len)) && (int'(pos) < OUT_BITS)) begin
				next_bits[pos[POS_W-1:0]] = code[CODE_W-1-i];
			end
		end
	end

	assign next_count = bit_count + bit_count_t'(code_len);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			packed_bits <= '0;
			bit_count <= '0;
		end else if (code_valid) begin
			packed_bits <= next_bits;
			bit_count <= next_count;
		end
	end

	// sticky until reset
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			done <= 1'b0;
		end else if (code_last) begin
			done <= 1'b1;
		end
	end

endmodule

//--- verilog/huffman_pack_top.sv
module huffman_pack_top #(
	parameter int N_SYMBOLS = 256,
	parameter int OUT_BITS = 1024
) (
	input  logic                                    CLK,
	input  logic                                    nRST,
	input  logic                                    run,
	input  huff_pkg::code_table_t                   code_table,
	input  logic [N_SYMBOLS*huff_pkg::SYMBOL_W-1:0] character_in,
	output logic [OUT_BITS-1:0]                     packed_bits,
	output huff_pkg::bit_count_t                    bit_count,
	output logic                                    done
);
	import huff_pkg::*;

	// reader to lookup
	symbol_t sym;
	logic sym_valid;
	logic sym_last;

	// lookup to packer
	code_bits_t code;
	code_len_t code_len;
	logic code_valid;
	logic code_last;

	symbol_reader #(
		.N_SYMBOLS(N_SYMBOLS)
	) u_reader (
		.CLK(CLK),
		.nRST(nRST),
		.run(run),
		.character_in(character_in),
		.sym(sym),
		.sym_valid(sym_valid),
		.sym_last(sym_last)
	);

	code_lookup u_lookup (
		.CLK(CLK),
		.nRST(nRST),
		.code_table(code_table),
		.sym(sym),
		.sym_valid(sym_valid),
		.sym_last(sym_last),
		.code(code),
		.code_len(code_len),
		.code_valid(code_valid),
		.code_last(code_last)
	);

	bit_packer #(
		.OUT_BITS(OUT_BITS)
	) u_packer (
		.CLK(CLK),
		.nRST(nRST),
		.code(code),
		.code_len(code_len),
		.code_valid(code_valid),
		.code_last(code_last),
		.packed_bits(packed_bits),
		.bit_count(bit_count),
		.done(done)
	);

endmodule

//--- verification/huffman_pack_sva.sv
module huffman_pack_sva (
	input logic                 CLK,
	input logic                 nRST,
	input logic                 done,
	input huff_pkg::bit_count_t bit_count,
	input logic                 sym_valid,
	input logic                 sym_last,
	input logic                 code_valid,
	input logic                 code_last
);
	timeunit 1ns;
	timeprecision 1ps;

	// done is sticky until reset
	done_held: assert property (@(posedge CLK) disable iff (!nRST) done |=> done)
		else $error("done fell while out of reset");

	count_rising: assert property (@(posedge CLK) disable iff (!nRST)
		bit_count >= $past(bit_count))
		else $error("bit_count decreased");

	// lookup stage is exactly one cycle
	valid_follows_sym: assert property (@(posedge CLK) disable iff (!nRST)
		code_valid |-> $past(sym_valid))
		else $error("code_valid without sym_valid one cycle earlier");

	last_follows_sym: assert property (@(posedge CLK) disable iff (!nRST)
		code_last |-> $past(sym_valid && sym_last))
		else $error("code_last without sym_last one cycle earlier");

endmodule

bind huffman_pack_top huffman_pack_sva u_sva (
	.CLK(CLK),
	.nRST(nRST),
	.done(done),
	.bit_count(bit_count),
	.sym_valid(sym_valid),
	.sym_last(sym_last),
	.code_valid(code_valid),
	.code_last(code_last)
);

//--- verification/huffman_pack_tb.sv
module huffman_pack_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import huff_pkg::*;

	localparam int N_SYMBOLS = 256;
	localparam int OUT_BITS = 1024;
	localparam int N_ROWS = 6;
	localparam int WORD_W = N_SYMBOLS * SYMBOL_W;
	localparam int MAX_CYCLES = 2 * (N_SYMBOLS + 60);

	// table modes
	localparam int TAB_FIXED = 0;
	localparam int TAB_LFSR = 1;
	localparam int TAB_ZERO_LEN = 2;

	// symbol modes
	localparam int SYM_CONST = 0;
	localparam int SYM_LFSR = 1;
	localparam int SYM_INVALID = 2;

	logic CLK;
	logic nRST;
	logic run;
	code_table_t code_table;
	logic [WORD_W-1:0] character_in;
	logic [OUT_BITS-1:0] packed_bits;
	bit_count_t bit_count;
	logic done;

	string row_name [N_ROWS];
	int row_tab [N_ROWS];
	int row_len [N_ROWS];
	int row_sym [N_ROWS];
	int row_val [N_ROWS];
	int row_stall [N_ROWS];
	int row_count [N_ROWS];

	logic [15:0] lfsr;
	symbol_t syms [N_SYMBOLS];
	logic [OUT_BITS-1:0] exp_bits;
	int exp_count;
	int fail_count;
	int failed_tests;

	huffman_pack_top #(
		.N_SYMBOLS(N_SYMBOLS),
		.OUT_BITS(OUT_BITS)
	) DUT (
		.CLK(CLK),
		.nRST(nRST),
		.run(run),
		.code_table(code_table),
		.character_in(character_in),
		.packed_bits(packed_bits),
		.bit_count(bit_count),
		.done(done)
	);

	always #10 CLK = ~CLK;

	// galois lfsr stepped once per bit
	function automatic logic rand_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 16'hB400;
		end
		return out;
	endfunction

	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r = (r << 1) | int'(rand_bit());
		end
		return r;
	endfunction

	task automatic set_row(input int r, input string name, input int tab, input int len,
			input int sym, input int val, input int stall, input int count);
		row_name[r] = name;
		row_tab[r] = tab;
		row_len[r] = len;
		row_sym[r] = sym;
		row_val[r] = val;
		row_stall[r] = stall;
		row_count[r] = count;
	endtask

	task automatic build_stimulus(input int r);
		logic [CODE_W-1:0] c;
		logic [LEN_W-1:0] l;
		int v;
		for (int k = 0; k < N_ENTRIES; k++) begin
			if (row_tab[r] == TAB_FIXED) begin
				c = 9'h165 ^ CODE_W'(k * 53);
				l = LEN_W'(row_len[r]);
			end else if (row_tab[r] == TAB_LFSR) begin
				c = CODE_W'(rand_bits(CODE_W));
				l = LEN_W'(rand_bits(LEN_W));
			end else begin
				c = CODE_W'(rand_bits(CODE_W));
				l = '0;
			end
			code_table[k*ENTRY_W +: ENTRY_W] = {c, l};
		end
		for (int i = 0; i < N_SYMBOLS; i++) begin
			if (row_sym[r] == SYM_CONST) begin
				v = row_val[r];
			end else if (row_sym[r] == SYM_LFSR) begin
				v = rand_bits(SYMBOL_W);
			end else begin
				// 0, 11 to 15, and 1 or 2 which hit zero-length entries
				v = rand_bits(3);
				v = (v == 0) ? 0 : ((v < 6) ? v + 10 : v - 5);
			end
			syms[i] = SYMBOL_W'(v);
			character_in[i*SYMBOL_W +: SYMBOL_W] = syms[i];
		end
	endtask

	// reference model of the packing rules
	task automatic compute_expected();
		logic [ENTRY_W-1:0] entry;
		int s;
		int len;
		exp_bits = '0;
		exp_count = 0;
		for (int i = 0; i < N_SYMBOLS; i++) begin
			s = int'(syms[i]);
			if (s >= 1 && s <= N_ENTRIES) begin
				entry = code_table[(s-1)*ENTRY_W +: ENTRY_W];
				len = int'(entry[LEN_W-1:0]);
				if (len >= 1 && len <= CODE_W) begin
					for (int j = 0; j < len; j++) begin
						if (exp_count < OUT_BITS) begin
							exp_bits[exp_count] = entry[ENTRY_W-1-j];
						end
						exp_count++;
					end
				end
			end
		end
	endtask

	task automatic run_row(input int r);
		int tot;
		int en;
		int tot_last;
		int tot_done;
		int bad;
		int errs_before;
		errs_before = fail_count;
		build_stimulus(r);
		compute_expected();
		nRST = 1'b0;
		run = 1'b0;
		repeat (10) @(posedge CLK);
		#2;
		nRST = 1'b1;
		if (packed_bits !== '0 || bit_count !== '0 || done !== 1'b0) begin
			$display("Fail %0t: %s outputs not cleared by reset", $time, row_name[r]);
			fail_count++;
		end
		tot = 0;
		en = 0;
		tot_last = -1;
		tot_done = -1;
		while (tot_done < 0 && tot < MAX_CYCLES) begin
			if (row_stall[r] != 0) begin
				run = (rand_bits(2) != 0);
			end else begin
				run = 1'b1;
			end
			@(posedge CLK);
			tot++;
			if (run) begin
				en++;
				// enabled edge that issues the last symbol
				if (en == N_SYMBOLS + 1) begin
					tot_last = tot;
				end
			end
			#2;
			if (done === 1'b1) begin
				tot_done = tot;
			end
		end
		run = 1'b0;
		if (tot_done < 0) begin
			$display("%s: done never rose within %0d cycles", row_name[r], MAX_CYCLES);
			fail_count++;
		end else begin
			if (tot_done != tot_last + 2) begin
				$display("Fail %0t: %s done at edge %0d, last symbol at edge %0d",
					$time, row_name[r], tot_done, tot_last);
				fail_count++;
			end
			if (row_stall[r] == 0 && en != N_SYMBOLS + 3) begin
				$display("Fail %0t: %s done at enabled edge %0d, expected %0d",
					$time, row_name[r], en, N_SYMBOLS + 3);
				fail_count++;
			end
			if (bit_count !== bit_count_t'(exp_count)) begin
				$display("Fail %0t: %s bit_count %0d, expected %0d",
					$time, row_name[r], bit_count, exp_count);
				fail_count++;
			end
			if (row_count[r] >= 0 && int'(bit_count) != row_count[r]) begin
				$display("Fail %0t: %s bit_count %0d, table gives %0d",
					$time, row_name[r], bit_count, row_count[r]);
				fail_count++;
			end
			if (packed_bits !== exp_bits) begin
				bad = -1;
				for (int i = OUT_BITS - 1; i >= 0; i--) begin
					if (packed_bits[i] !== exp_bits[i]) begin
						bad = i;
					end
				end
				$display("Fail %0t: %s packed_bits differ first at bit %0d",
					$time, row_name[r], bad);
				fail_count++;
			end
		end
		if (fail_count == errs_before) begin
			$display("test %0d %s: ok, %0d bits", r, row_name[r], exp_count);
		end else begin
			$display("test %0d %s: %0d errors", r, row_name[r], fail_count - errs_before);
			failed_tests++;
		end
	endtask

	initial begin
		CLK = 1'b0;
		nRST = 1'b0;
		run = 1'b0;
		code_table = '0;
		character_in = '0;
		lfsr = 16'd5;
		fail_count = 0;
		failed_tests = 0;
		set_row(0, "const_short", TAB_FIXED, 2, SYM_CONST, 1, 0, 512);
		set_row(1, "lfsr_symbols", TAB_LFSR, 0, SYM_LFSR, 0, 0, -1);
		set_row(2, "invalid_only", TAB_ZERO_LEN, 0, SYM_INVALID, 0, 0, 0);
		set_row(3, "overflow", TAB_FIXED, 9, SYM_CONST, 5, 0, 2304);
		set_row(4, "stall_lfsr", TAB_LFSR, 0, SYM_LFSR, 0, 1, -1);
		set_row(5, "stall_overflow", TAB_FIXED, 9, SYM_CONST, 7, 1, 2304);
		for (int r = 0; r < N_ROWS; r++) begin
			run_row(r);
		end
		$display("tests %0d, failed tests %0d, failed checks %0d",
			N_ROWS, failed_tests, fail_count);
		if (fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(N_ROWS * (N_SYMBOLS + 60) * 20 * 2);
		$display("watchdog expired before all tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- filelist.f
verilog/huff_pkg.sv
verilog/symbol_reader.sv
verilog/code_lookup.sv
verilog/bit_packer.sv
verilog/huffman_pack_top.sv
verification/huffman_pack_sva.sv
verification/huffman_pack_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := huffman_pack_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Simulation finished: PASS

SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
